/* kl10ebus.f */
+incdir+src
src/ebusPkg.sv
src/creditFifo.sv
src/respSender.sv
src/diagSequencer.sv
src/diagRegBoard.sv
src/ebusMux.sv
src/kl10ebus.sv
tb/kl10ebusTb.sv

/* src/creditFifo.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module creditFifo
  import ebusPkg::*;
#(
  parameter type tItem = tDiagReq,
  parameter int depth = `REQ_DEPTH
)
(
  input logic clk60,
  input logic arstN,
  input logic inValid,
  input tItem inItem,
  output logic outValid,
  output tItem outItem,
  input logic take,
  output logic creditReturn
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = ptrWidth + 1;
  localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);
  localparam logic [cntWidth-1:0] fullCount = cntWidth'(depth);

  tItem mem [depth];
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [cntWidth-1:0] count;
  logic pop;

  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
    if (p == lastPtr)
      return '0;
    return p + 1'b1;
  endfunction

  assign outValid = count != '0;
  assign outItem = mem[rdPtr];
  assign pop = take && outValid;
  // Each entry that leaves frees one slot upstream
  assign creditReturn = pop;

  always_ff @(posedge clk60)
  begin
    if (inValid)
      mem[wrPtr] <= inItem;
  end

  always_ff @(posedge clk60 or negedge arstN)
  begin
    if (!arstN)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (inValid)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      case ({inValid, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  noPushWhenFull: assert property (@(posedge clk60) disable iff (!arstN)
    inValid |-> count != fullCount);
  noTakeWhenEmpty: assert property (@(posedge clk60) disable iff (!arstN)
    take |-> outValid);

endmodule

/* src/diagRegBoard.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module diagRegBoard
  import ebusPkg::*;
#(
  parameter int boardNum = 1,
  parameter int sliceLo = 0,
  parameter int sliceHi = `EBUS_WIDTH - 1
)
(
  input logic clk60,
  input logic arstN,
  input tEbusCtl ctl,
  output tEBUSdriver driver
);

  localparam int numRegs = 1 << `REG_WIDTH;
  localparam logic [`BOARD_WIDTH-1:0] myBoard = boardNum[`BOARD_WIDTH-1:0];

  logic [sliceLo:sliceHi] regs [numRegs];
  logic selected;
  logic [`REG_WIDTH-1:0] regSel;

  assign selected = ctl.ds[0:`BOARD_WIDTH-1] == myBoard;
  assign regSel = ctl.ds[`BOARD_WIDTH:`DS_WIDTH-1];

  always_ff @(posedge clk60 or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < numRegs; i++)
        regs[i] <= '0;
    end
    else if (ctl.diagStrobe && selected)
    begin
      regs[regSel] <= ctl.wrData[sliceLo:sliceHi];
    end
  end

  // Bits outside the owned slice read as zero
  always_comb
  begin
    driver.driving = ctl.readEn && selected;
    driver.data = '0;
    if (driver.driving)
      driver.data[sliceLo:sliceHi] = regs[regSel];
  end

  oneCycleKind: assert property (@(posedge clk60) disable iff (!arstN)
    !(ctl.diagStrobe && ctl.readEn));

endmodule

/* src/diagSequencer.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module diagSequencer
  import ebusPkg::*;
(
  input logic clk60,
  input logic arstN,
  input logic headValid,
  input tDiagReq head,
  output logic take,
  input logic slotFree,
  input logic [0:`EBUS_WIDTH-1] ebusData,
  output tEbusCtl ctl,
  output logic pushValid,
  output tDiagResp pushItem
);

  localparam int creditWidth = $clog2(`RESP_DEPTH + 1);
  localparam logic [creditWidth-1:0] maxCredits = creditWidth'(`RESP_DEPTH);

  typedef enum logic {
    seqIdle,
    seqIssue
  } tSeqState;

  tSeqState state;
  logic [creditWidth-1:0] respCredits;
  logic spendRead;
  logic [0:`DS_WIDTH-1] ctlDs;
  logic [0:`EBUS_WIDTH-1] ctlWrData;
  logic strobeQ;
  logic readEnQ;

  // A read needs room reserved in the response queue before it is taken
  assign take = (state == seqIdle) && headValid && (head.write || respCredits != '0);
  assign spendRead = take && !head.write;

  assign ctl = '{ds: ctlDs, diagStrobe: strobeQ, readEn: readEnQ, wrData: ctlWrData};

  always_ff @(posedge clk60 or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= seqIdle;
      strobeQ <= 1'b0;
      readEnQ <= 1'b0;
      pushValid <= 1'b0;
      respCredits <= maxCredits;
    end
    else
    begin
      state <= take ? seqIssue : seqIdle;
      strobeQ <= take && head.write;
      readEnQ <= spendRead;
      // Bus word is sampled in the cycle readEn is up
      pushValid <= (state == seqIssue) && readEnQ;
      respCredits <= respCredits - spendRead + slotFree;
    end
  end

  always_ff @(posedge clk60)
  begin
    if (take)
    begin
      ctlDs <= head.ds;
      ctlWrData <= head.data;
    end
    if (readEnQ)
    begin
      pushItem.ds <= ctlDs;
      pushItem.data <= ebusData;
    end
  end

  creditBound: assert property (@(posedge clk60) disable iff (!arstN)
    respCredits <= maxCredits);

endmodule

/* src/ebusMux.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module ebusMux
  import ebusPkg::*;
#(
  parameter int numFull = `NUM_FULL_BOARDS
)
(
  input tEBUSdriver fullDrivers [numFull],
  input tEBUSdriver sliceDrivers [`NUM_SLICES],
  output logic [0:`EBUS_WIDTH-1] ebusData
);

  logic [numFull-1:0] fullDriving;
  logic sliceDriving;

  always_comb
  begin
    sliceDriving = 1'b0;
    for (int s = 0; s < `NUM_SLICES; s++)
      sliceDriving |= sliceDrivers[s].driving;
    for (int i = 0; i < numFull; i++)
      fullDriving[i] = fullDrivers[i].driving;
  end

  // Card 0 holds the low-order slice, the last card holds bits 0 to 5
  always_comb
  begin
    ebusData = '0;
    if (sliceDriving)
    begin
      for (int s = 0; s < `NUM_SLICES; s++)
        ebusData[(`NUM_SLICES-1-s)*`SLICE_WIDTH +: `SLICE_WIDTH] =
          sliceDrivers[s].data[(`NUM_SLICES-1-s)*`SLICE_WIDTH +: `SLICE_WIDTH];
    end
    // Walk from the far end so the lowest driving index wins
    for (int i = numFull - 1; i >= 0; i--)
    begin
      if (fullDrivers[i].driving)
        ebusData = fullDrivers[i].data;
    end
  end

  singleDriver: assert final ($onehot0({fullDriving, sliceDriving}));

endmodule

/* src/ebusPkg.sv */
`include "ebus_settings.svh"

package ebusPkg;

  // Control lines the sequencer drives to every board
  typedef struct packed {
    logic [0:`DS_WIDTH-1] ds;
    logic diagStrobe;
    logic readEn;
    logic [0:`EBUS_WIDTH-1] wrData;
  } tEbusCtl;

  // What one board puts on the EBUS data lines
  typedef struct packed {
    logic driving;
    logic [0:`EBUS_WIDTH-1] data;
  } tEBUSdriver;

  typedef struct packed {
    logic write;
    logic [0:`DS_WIDTH-1] ds;
    logic [0:`EBUS_WIDTH-1] data;
  } tDiagReq;

  typedef struct packed {
    logic [0:`DS_WIDTH-1] ds;
    logic [0:`EBUS_WIDTH-1] data;
  } tDiagResp;

endpackage

/* src/ebus_settings.svh */
`ifndef EBUS_SETTINGS_SVH
`define EBUS_SETTINGS_SVH

// EBUS data word, bit 0 is the most significant
`define EBUS_WIDTH 36

// Diagnostic select is a board number followed by a register number
`define DS_WIDTH 7
`define BOARD_WIDTH 4
`define REG_WIDTH 3

`define REQ_DEPTH 4
`define RESP_DEPTH 4
`define DOWN_CREDIT_WIDTH 16

// Full boards are numbered 1 to NUM_FULL_BOARDS
`define NUM_FULL_BOARDS 3

// Slice cards all answer to one board number, each owns SLICE_WIDTH bits
`define SLICE_BOARD 5
`define NUM_SLICES 6
`define SLICE_WIDTH 6

`endif

/* src/kl10ebus.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module kl10ebus
  import ebusPkg::*;
(
  input logic clk60,
  input logic arstN,
  input logic reqValid,
  input tDiagReq req,
  output logic reqCredit,
  input logic respCredit,
  output logic respValid,
  output tDiagResp resp
);

  logic headValid;
  tDiagReq head;
  logic take;
  logic slotFree;
  tEbusCtl ctl;
  tEBUSdriver fullDrivers [`NUM_FULL_BOARDS];
  tEBUSdriver sliceDrivers [`NUM_SLICES];
  logic [0:`EBUS_WIDTH-1] ebusData;
  logic pushValid;
  tDiagResp pushItem;

  creditFifo #(.tItem(tDiagReq), .depth(`REQ_DEPTH)) reqQueue (
    .clk60(clk60), .arstN(arstN),
    .inValid(reqValid), .inItem(req),
    .outValid(headValid), .outItem(head),
    .take(take), .creditReturn(reqCredit)
  );

  diagSequencer sequencer (
    .clk60(clk60), .arstN(arstN),
    .headValid(headValid), .head(head), .take(take),
    .slotFree(slotFree), .ebusData(ebusData), .ctl(ctl),
    .pushValid(pushValid), .pushItem(pushItem)
  );

  for (genvar b = 0; b < `NUM_FULL_BOARDS; b++)
  begin : fullBoard
    diagRegBoard #(.boardNum(b + 1), .sliceLo(0), .sliceHi(`EBUS_WIDTH - 1)) board (
      .clk60(clk60), .arstN(arstN), .ctl(ctl), .driver(fullDrivers[b])
    );
  end

  for (genvar s = 0; s < `NUM_SLICES; s++)
  begin : sliceCard
    localparam int lo = (`NUM_SLICES - 1 - s) * `SLICE_WIDTH;
    diagRegBoard #(.boardNum(`SLICE_BOARD), .sliceLo(lo), .sliceHi(lo + `SLICE_WIDTH - 1)) card (
      .clk60(clk60), .arstN(arstN), .ctl(ctl), .driver(sliceDrivers[s])
    );
  end

  ebusMux #(.numFull(`NUM_FULL_BOARDS)) mux (
    .fullDrivers(fullDrivers), .sliceDrivers(sliceDrivers), .ebusData(ebusData)
  );

  respSender sender (
    .clk60(clk60), .arstN(arstN),
    .pushValid(pushValid), .pushItem(pushItem),
    .respCredit(respCredit), .respValid(respValid), .resp(resp),
    .slotFree(slotFree)
  );

endmodule

/* src/respSender.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module respSender
  import ebusPkg::*;
(
  input logic clk60,
  input logic arstN,
  input logic pushValid,
  input tDiagResp pushItem,
  input logic respCredit,
  output logic respValid,
  output tDiagResp resp,
  output logic slotFree
);

  logic headValid;
  tDiagResp headItem;
  logic send;
  logic [`DOWN_CREDIT_WIDTH-1:0] downCredits;

  creditFifo #(.tItem(tDiagResp), .depth(`RESP_DEPTH)) respQueue (
    .clk60(clk60),
    .arstN(arstN),
    .inValid(pushValid),
    .inItem(pushItem),
    .outValid(headValid),
    .outItem(headItem),
    .take(send),
    .creditReturn(slotFree)
  );

  // One response per downstream credit, oldest first
  assign send = headValid && (downCredits != '0);
  assign respValid = send;
  assign resp = headItem;

  always_ff @(posedge clk60 or negedge arstN)
  begin
    if (!arstN)
      downCredits <= '0;
    else
      downCredits <= downCredits + respCredit - send;
  end

  noCreditWrap: assert property (@(posedge clk60) disable iff (!arstN)
    (respCredit && !send) |-> downCredits != '1);

endmodule

/* tb/kl10ebusTb.sv */
`timescale 1ns/1ps
`include "ebus_settings.svh"

module kl10ebusTb
  import ebusPkg::*;
();

  localparam int totalRequests = 48 + 20 + 16 + 12;
  localparam int timeoutCycles = totalRequests * 20 + 500;

  logic clk60;
  logic arstN;
  logic reqValid;
  tDiagReq req;
  logic reqCredit;
  logic respCredit;
  logic respValid;
  tDiagResp resp;

  int seed;
  int errorCount;
  int testsRun;
  int testsFailed;
  int reqCredits;
  int reqAccepted;
  int creditPulses;
  int readsSent;
  int respGranted;
  int respReceived;
  int earlyGrants;
  logic creditsOn;
  tDiagResp expQ [$];
  tDiagResp expHead;
  logic [0:`EBUS_WIDTH-1] model [16][8];

  kl10ebus UUT (
    .clk60(clk60), .arstN(arstN),
    .reqValid(reqValid), .req(req), .reqCredit(reqCredit),
    .respCredit(respCredit), .respValid(respValid), .resp(resp)
  );

  always #50 clk60 = ~clk60;

  function automatic logic [0:`DS_WIDTH-1] makeDs(input int board, input int regNum);
    return {board[`BOARD_WIDTH-1:0], regNum[`REG_WIDTH-1:0]};
  endfunction

  // Boards with no card behind them read as zero
  function automatic logic [0:`EBUS_WIDTH-1] expectedRead(input logic [0:`DS_WIDTH-1] ds);
    int board;
    int regNum;
    board = ds[0:`BOARD_WIDTH-1];
    regNum = ds[`BOARD_WIDTH:`DS_WIDTH-1];
    if ((board >= 1 && board <= `NUM_FULL_BOARDS) || board == `SLICE_BOARD)
      return model[board][regNum];
    return '0;
  endfunction

  function automatic logic [0:`EBUS_WIDTH-1] randomWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`EBUS_WIDTH-1:0];
  endfunction

  task automatic sendReq(input logic write, input int board, input int regNum,
                         input logic [0:`EBUS_WIDTH-1] data);
    logic [0:`DS_WIDTH-1] ds;
    ds = makeDs(board, regNum);
    while (reqCredits == 0)
    begin
      @(posedge clk60);
      #1;
    end
    reqValid = 1'b1;
    req = '{write: write, ds: ds, data: data};
    if (write)
      model[board][regNum] = data;
    else
    begin
      expQ.push_back('{ds: ds, data: expectedRead(ds)});
      readsSent++;
    end
    @(posedge clk60);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic waitDrained(input int limit);
    int cycles;
    logic drained;
    cycles = 0;
    drained = respReceived == readsSent && reqCredits == `REQ_DEPTH;
    while (!drained && cycles < limit)
    begin
      @(posedge clk60);
      #1;
      cycles++;
      drained = respReceived == readsSent && reqCredits == `REQ_DEPTH;
    end
    assert (drained)
    else
    begin
      errorCount++;
      $display("Requests or responses did not drain within %0d cycles", limit);
    end
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testsRun++;
    if (errorCount == startErrors)
      $display("Test %s: ok", name);
    else
    begin
      testsFailed++;
      $display("Test %s: %0d errors", name, errorCount - startErrors);
    end
  endtask

  // Requester credits, downstream grants and response order
  always @(posedge clk60)
  begin
    if (arstN)
    begin
      if (reqValid)
        reqAccepted++;
      if (reqCredit)
        creditPulses++;
      reqCredits = reqCredits - (reqValid ? 1 : 0) + (reqCredit ? 1 : 0);
      if (respCredit)
        respGranted++;
      if (respValid && expQ.size() != 0)
      begin
        expHead = expQ.pop_front();
        assert (resp.data == expHead.data)
        else
        begin
          errorCount++;
          $display("Error: resp.data = %h, expected %h", resp.data, expHead.data);
        end
        assert (resp.ds == expHead.ds)
        else
        begin
          errorCount++;
          $display("Error: resp.ds = %h, expected %h", resp.ds, expHead.ds);
        end
      end
      if (respValid)
        respReceived++;
    end
  end

  // Sink grants a few credits up front, then at random spacing up to the reads sent
  always @(posedge clk60)
  begin
    #1;
    respCredit = 1'b0;
    if (earlyGrants > 0)
    begin
      respCredit = 1'b1;
      earlyGrants--;
    end
    else if (creditsOn && respGranted < readsSent && ($random(seed) & 1))
      respCredit = 1'b1;
  end

  respNeedsRead: assert property (@(posedge clk60) disable iff (!arstN)
    respValid |-> readsSent > respReceived)
  else
  begin
    errorCount++;
    $display("A response appeared with no read outstanding");
  end

  respWithinCredit: assert property (@(posedge clk60) disable iff (!arstN)
    respValid |-> respGranted > respReceived)
  else
  begin
    errorCount++;
    $display("A response was sent without a downstream credit");
  end

  creditPerRequest: assert property (@(posedge clk60) disable iff (!arstN)
    reqCredit |-> reqAccepted > creditPulses)
  else
  begin
    errorCount++;
    $display("A reqCredit pulse came without an accepted request");
  end

  reqCreditsInRange: assert property (@(posedge clk60) disable iff (!arstN)
    reqCredits >= 0 && reqCredits <= `REQ_DEPTH)
  else
  begin
    errorCount++;
    $display("Error: reqCredits = %h, outside 0 to %h", reqCredits, `REQ_DEPTH);
  end

  initial
  begin
    repeat (timeoutCycles) @(posedge clk60);
    $display("Run stopped by the watchdog after %0d cycles", timeoutCycles);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    int startErrors;
    int boardList [4];
    int pick;
    int receivedBefore;
    int readsBefore;
    logic isWrite;
    seed = 32'he245;
    clk60 = 1'b0;
    arstN = 1'b0;
    reqValid = 1'b0;
    req = '0;
    respCredit = 1'b0;
    creditsOn = 1'b0;
    earlyGrants = 0;
    reqCredits = `REQ_DEPTH;
    boardList[0] = 1;
    boardList[1] = 2;
    boardList[2] = 3;
    boardList[3] = `SLICE_BOARD;
    for (int b = 0; b < 16; b++)
      for (int r = 0; r < 8; r++)
        model[b][r] = '0;
    repeat (10) @(posedge clk60);
    #1;
    arstN = 1'b1;

    startErrors = errorCount;
    assert (!respValid && !reqCredit)
    else
    begin
      errorCount++;
      $display("Error: respValid = %h, reqCredit = %h, expected 0", respValid, reqCredit);
    end
    // Sender holds downstream credits while no read has been sent
    earlyGrants = 3;
    creditsOn = 1'b1;
    repeat (20) @(posedge clk60);
    #1;
    finishTest("afterReset", startErrors);

    startErrors = errorCount;
    for (int b = 1; b <= `NUM_FULL_BOARDS; b++)
      for (int r = 0; r < 8; r++)
        sendReq(1'b1, b, r, randomWord());
    for (int b = 1; b <= `NUM_FULL_BOARDS; b++)
      for (int r = 0; r < 8; r++)
        sendReq(1'b0, b, r, '0);
    waitDrained(600);
    finishTest("fullBoards", startErrors);

    startErrors = errorCount;
    for (int r = 0; r < 8; r++)
      sendReq(1'b1, `SLICE_BOARD, r, randomWord());
    sendReq(1'b1, 9, 2, randomWord());
    for (int r = 0; r < 8; r++)
      sendReq(1'b0, `SLICE_BOARD, r, '0);
    sendReq(1'b0, 9, 2, '0);
    sendReq(1'b0, 4, 0, '0);
    sendReq(1'b0, 15, 7, '0);
    waitDrained(400);
    finishTest("sliceAndUnmapped", startErrors);

    startErrors = errorCount;
    for (int i = 0; i < 16; i++)
    begin
      pick = $random(seed) & 3;
      isWrite = $random(seed) & 1;
      sendReq(isWrite, boardList[pick], $random(seed) & 7, isWrite ? randomWord() : '0);
    end
    waitDrained(400);
    assert (creditPulses == reqAccepted)
    else
    begin
      errorCount++;
      $display("Error: reqCredit pulses = %h, expected %h", creditPulses, reqAccepted);
    end
    finishTest("creditAccounting", startErrors);

    // Withhold downstream credits until both queues back up
    startErrors = errorCount;
    creditsOn = 1'b0;
    receivedBefore = respReceived;
    readsBefore = readsSent;
    fork
      for (int i = 0; i < 12; i++)
        sendReq(1'b0, 2, i % 8, '0);
      begin
        repeat (40) @(posedge clk60);
        #1;
        assert (respReceived == receivedBefore)
        else
        begin
          errorCount++;
          $display("Responses arrived while downstream credits were withheld");
        end
        assert (reqCredits == 0 && readsSent - readsBefore < 12)
        else
        begin
          errorCount++;
          $display("Requests did not stall while downstream credits were withheld");
        end
        creditsOn = 1'b1;
      end
    join
    waitDrained(600);
    assert (reqCredits == `REQ_DEPTH && creditPulses == reqAccepted)
    else
    begin
      errorCount++;
      $display("Error: reqCredits = %h, expected %h", reqCredits, `REQ_DEPTH);
    end
    finishTest("backPressure", startErrors);

    $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
